//--- conv_cases.txt
100 -200 200 400 500 0
101 -198 202 404 5 1
101 -198 202 404 0 1
99 -202 197 398 9 1
109 -222 217 438 50 0
106 -218 205 522 85 0
108 -221 209 508 15 1
98 -241 184 478 45 0
99 -242 187 473 6 1
103 -234 197 485 18 1
-497 566 197 485 1000 0
-497 566 197 485 0 1
-497 578 181 485 20 1
-521 578 181 453 40 0
-514 578 181 453 7 1
-508 584 188 453 11 1

//--- ica_conv.f
ica_pkg.sv
cordic_pkg.sv
cordic_if.sv
cordic_vec.sv
vector_norm.sv
sample_loader.sv
conv_control.sv
ica_conv_top.sv
tb_ica_conv.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ica_conv -f ica_conv.f -o sim_ica_conv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_ica_conv
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit 1
fi

exit 0

//--- tb_ica_conv.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ica_conv import ica_pkg::*; ();

    localparam int NORM_TOL     = 4;
    localparam int LOAD_TIMEOUT = 100;
    localparam int DONE_TIMEOUT = 400;

    logic    clk;
    logic    nreset;
    logic    start;
    sample_t sample_in;
    logic    sample_valid;
    logic    sample_ready;
    logic    done;
    norm_t   diff_norm;
    logic    converged;

    integer  seed;

    ica_conv_top dut0 (
        .clk          (clk),
        .nreset       (nreset),
        .start        (start),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .done         (done),
        .diff_norm    (diff_norm),
        .converged    (converged)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_failed();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic fail_with(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        stop_failed();
    endtask

    // Equal within tol
    task automatic check_value(input string name, input int got, input int exp, input int tol);
        int delta;
        delta = got - exp;
        if (delta < 0) begin
            delta = -delta;
        end
        if (delta > tol) begin
            $display("MISMATCH at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            stop_failed();
        end
    endtask

    // Loads one vector with random gaps in sample_valid
    task automatic load_vector(input int samples [DIM]);
        int idx;
        int cycles;
        idx    = 0;
        cycles = 0;
        while (idx < DIM) begin
            @(negedge clk);
            check_value("sample_ready", int'(sample_ready), 1, 0);
            if (($random(seed) & 3) == 0) begin
                sample_valid = 1'b0;
                sample_in    = sample_t'($random(seed));
            end else begin
                sample_valid = 1'b1;
                sample_in    = sample_t'(samples[idx]);
                idx++;
            end
            cycles++;
            if (cycles > LOAD_TIMEOUT) begin
                fail_with("sample loading did not finish within the timeout");
            end
        end
        @(negedge clk);
        sample_valid = 1'b0;
        check_value("sample_ready", int'(sample_ready), 0, 0);
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done) begin
            @(negedge clk);
            check_value("sample_ready", int'(sample_ready), 0, 0);
            cycles++;
            if (cycles > DONE_TIMEOUT) begin
                fail_with("done did not rise within the timeout");
            end
        end
    endtask

    task automatic run_case(input int samples [DIM], input int exp_norm, input int exp_flag);
        int hold;
        @(negedge clk);
        start = 1'b1;
        load_vector(samples);
        wait_done();
        check_value("diff_norm", int'(diff_norm), exp_norm, NORM_TOL);
        check_value("converged", int'(converged), exp_flag, 0);
        // Result stays valid while start is held
        hold = 1 + ($random(seed) & 3);
        repeat (hold) begin
            @(negedge clk);
            check_value("done", int'(done), 1, 0);
            check_value("diff_norm", int'(diff_norm), exp_norm, NORM_TOL);
            check_value("converged", int'(converged), exp_flag, 0);
        end
        start = 1'b0;
        @(negedge clk);
        check_value("done", int'(done), 0, 0);
        check_value("sample_ready", int'(sample_ready), 0, 0);
    endtask

    initial begin
        int fd;
        int rc;
        int runs;
        int samples [DIM];
        int exp_norm;
        int exp_flag;

        seed         = 32'h5affa88b;
        nreset       = 1'b0;
        start        = 1'b0;
        sample_in    = '0;
        sample_valid = 1'b0;
        repeat (3) @(negedge clk);
        nreset = 1'b1;

        // Nothing to load before start
        repeat (4) begin
            @(negedge clk);
            check_value("done", int'(done), 0, 0);
            check_value("sample_ready", int'(sample_ready), 0, 0);
        end

        fd = $fopen("conv_cases.txt", "r");
        if (fd == 0) begin
            fail_with("could not open conv_cases.txt");
        end
        runs = 0;
        rc = $fscanf(fd, "%d %d %d %d %d %d\n", samples[0], samples[1], samples[2],
                     samples[3], exp_norm, exp_flag);
        while (rc == DIM + 2) begin
            run_case(samples, exp_norm, exp_flag);
            runs++;
            rc = $fscanf(fd, "%d %d %d %d %d %d\n", samples[0], samples[1], samples[2],
                         samples[3], exp_norm, exp_flag);
        end
        if (!$feof(fd)) begin
            fail_with("conv_cases.txt holds a line that is not a valid case");
        end
        $fclose(fd);

        if (runs == 0) begin
            fail_with("no cases were read from conv_cases.txt");
        end else begin
            $display("Completed %0d runs", runs);
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- ica_conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module ica_conv_top import ica_pkg::*; (
    input  logic    clk,
    input  logic    nreset,
    input  logic    start,
    input  sample_t sample_in,
    input  logic    sample_valid,
    output logic    sample_ready,
    output logic    done,
    output norm_t   diff_norm,
    output logic    converged
);

    logic      load_en;
    logic      loaded;
    vec_t      vec;
    logic      norm_req;
    logic      norm_ack;
    diff_vec_t diff_vec;
    norm_t     norm;

    // Norm sequencer to CORDIC
    cordic_if cif ();

    sample_loader u_loader (
        .clk          (clk),
        .nreset       (nreset),
        .load_en      (load_en),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .vec          (vec),
        .loaded       (loaded)
    );

    conv_control u_ctrl (
        .clk       (clk),
        .nreset    (nreset),
        .start     (start),
        .loaded    (loaded),
        .vec       (vec),
        .norm_ack  (norm_ack),
        .norm      (norm),
        .load_en   (load_en),
        .norm_req  (norm_req),
        .diff_vec  (diff_vec),
        .done      (done),
        .diff_norm (diff_norm),
        .converged (converged)
    );

    vector_norm u_norm (
        .clk      (clk),
        .nreset   (nreset),
        .norm_req (norm_req),
        .diff_vec (diff_vec),
        .norm_ack (norm_ack),
        .norm     (norm),
        .cli      (cif.client)
    );

    cordic_vec u_cordic (
        .clk    (clk),
        .nreset (nreset),
        .srv    (cif.server)
    );

endmodule

`default_nettype wire

//--- conv_control.sv
`timescale 1ns/1ps
`default_nettype none

module conv_control import ica_pkg::*; (
    input  logic      clk,
    input  logic      nreset,
    input  logic      start,
    input  logic      loaded,
    input  vec_t      vec,
    input  logic      norm_ack,
    input  norm_t     norm,
    output logic      load_en,
    output logic      norm_req,
    output diff_vec_t diff_vec,
    output logic      done,
    output norm_t     diff_norm,
    output logic      converged
);

    conv_state_t state;
    vec_t        prev;
    logic        norm_taken;

    assign load_en    = (state == LOAD);
    assign norm_req   = (state == NORM);
    assign norm_taken = norm_req && norm_ack;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state     <= IDLE;
            done      <= 1'b0;
            converged <= 1'b0;
            for (int i = 0; i < DIM; i++) begin
                prev[i] <= '0;
            end
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    if (loaded) begin
                        state <= DIFF;
                    end
                end
                DIFF: begin
                    state <= NORM;
                end
                NORM: begin
                    if (norm_ack) begin
                        state     <= REPORT;
                        done      <= 1'b1;
                        converged <= (norm <= THRESHOLD);
                        // New vector becomes the reference for the next run
                        prev      <= vec;
                    end
                end
                REPORT: begin
                    // Hold done until start is released
                    if (!start) begin
                        state <= IDLE;
                        done  <= 1'b0;
                    end
                end
                default: begin
                    state <= IDLE;
                    done  <= 1'b0;
                end
            endcase
        end
    end

    // Element-wise new minus old
    always_ff @(posedge clk) begin
        if (state == DIFF) begin
            for (int i = 0; i < DIM; i++) begin
                diff_vec[i] <= diff_t'(vec[i]) - diff_t'(prev[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (norm_taken) begin
            diff_norm <= norm;
        end
    end

    // A new run only starts once done has dropped
    a_start_after_done: assert property (
        @(posedge clk) disable iff (!nreset)
        $rose(start) |-> !done
    );

endmodule

`default_nettype wire

//--- sample_loader.sv
`timescale 1ns/1ps
`default_nettype none

module sample_loader import ica_pkg::*; (
    input  logic    clk,
    input  logic    nreset,
    input  logic    load_en,
    input  sample_t sample_in,
    input  logic    sample_valid,
    output logic    sample_ready,
    output vec_t    vec,
    output logic    loaded
);

    localparam int CNT_W = $clog2(DIM + 1);
    localparam int IDX_W = $clog2(DIM);

    logic [CNT_W-1:0] count;
    logic             take;

    // Window open until the vector is full
    assign sample_ready = load_en && (count < CNT_W'(DIM));
    assign take         = sample_valid && sample_ready;
    assign loaded       = (count == CNT_W'(DIM));

    always_ff @(posedge clk) begin
        if (!nreset) begin
            count <= '0;
        end else if (!load_en) begin
            count <= '0;
        end else if (take) begin
            count <= count + 1'b1;
        end
    end

    // Sample lands at the next free index
    always_ff @(posedge clk) begin
        if (take) begin
            vec[count[IDX_W-1:0]] <= sample_in;
        end
    end

    // Window only closes on a full vector
    a_full_on_close: assert property (
        @(posedge clk) disable iff (!nreset)
        $fell(load_en) |-> $past(loaded)
    );

endmodule

`default_nettype wire

//--- vector_norm.sv
`timescale 1ns/1ps
`default_nettype none

module vector_norm import ica_pkg::*, cordic_pkg::*; (
    input  logic      clk,
    input  logic      nreset,
    input  logic      norm_req,
    input  diff_vec_t diff_vec,
    output logic      norm_ack,
    output norm_t     norm,
    cordic_if.client  cli
);

    localparam int IDX_W  = $clog2(DIM);
    localparam int PROD_W = CORDIC_WIDTH + GAIN_WIDTH;
    localparam int SHIFT  = GAIN_WIDTH + GUARD_BITS;

    typedef enum logic [1:0] {
        N_IDLE,
        N_REQ,
        N_REL,
        N_DONE
    } norm_state_t;

    norm_state_t           state;
    logic [IDX_W-1:0]      idx;
    norm_t                 running;
    logic [SAMPLE_WIDTH:0] first_abs;
    logic [PROD_W-1:0]     prod;
    norm_t                 scaled;

    assign first_abs = diff_vec[0][SAMPLE_WIDTH] ? -diff_vec[0] : diff_vec[0];

    // Remove the CORDIC gain and guard bits, round to nearest
    assign prod   = PROD_W'(unsigned'(cli.mag)) * PROD_W'(GAIN_INV);
    assign scaled = norm_t'((prod + (PROD_W'(1) << (SHIFT - 1))) >> SHIFT);

    // Operands stay put while req is high
    assign cli.x   = cordic_t'(running);
    assign cli.y   = cordic_t'(diff_vec[idx]);
    assign cli.req = (state == N_REQ);

    assign norm_ack = (state == N_DONE);
    assign norm     = running;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state <= N_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                N_IDLE: begin
                    if (norm_req) begin
                        idx   <= IDX_W'(1);
                        state <= N_REQ;
                    end
                end
                N_REQ: begin
                    if (cli.ack) begin
                        state <= N_REL;
                    end
                end
                N_REL: begin
                    // Wait for the CORDIC to drop ack
                    if (!cli.ack) begin
                        if (idx == IDX_W'(DIM - 1)) begin
                            state <= N_DONE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= N_REQ;
                        end
                    end
                end
                N_DONE: begin
                    if (!norm_req) begin
                        state <= N_IDLE;
                    end
                end
                default: state <= N_IDLE;
            endcase
        end
    end

    // Running partial norm
    always_ff @(posedge clk) begin
        if (state == N_IDLE && norm_req) begin
            running <= norm_t'(first_abs);
        end else if (state == N_REQ && cli.ack) begin
            running <= scaled;
        end
    end

endmodule

`default_nettype wire

//--- cordic_vec.sv
`timescale 1ns/1ps
`default_nettype none

module cordic_vec import cordic_pkg::*; (
    input  logic     clk,
    input  logic     nreset,
    cordic_if.server srv
);

    localparam int STAGE_W = $clog2(CORDIC_STAGES + 1);

    cordic_t            x_q;
    cordic_t            y_q;
    cordic_t            x_in;
    cordic_t            y_in;
    logic [STAGE_W-1:0] stage;
    logic               busy;
    logic               ack_q;
    logic               accept;

    // New request only once the previous ack has dropped
    assign accept = srv.req && !busy && !ack_q;

    // Fold into the right half-plane, then add the guard bits
    always_comb begin
        x_in = srv.x <<< GUARD_BITS;
        y_in = srv.y <<< GUARD_BITS;
        if (srv.x < 0) begin
            x_in = -x_in;
            y_in = -y_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            busy  <= 1'b0;
            ack_q <= 1'b0;
            stage <= '0;
        end else if (busy) begin
            // One spare cycle after the last micro-rotation
            if (stage == STAGE_W'(CORDIC_STAGES)) begin
                busy  <= 1'b0;
                ack_q <= 1'b1;
            end else begin
                stage <= stage + 1'b1;
            end
        end else if (ack_q) begin
            if (!srv.req) begin
                ack_q <= 1'b0;
            end
        end else if (srv.req) begin
            busy  <= 1'b1;
            stage <= '0;
        end
    end

    // Micro-rotations drive y toward zero
    always_ff @(posedge clk) begin
        if (accept) begin
            x_q <= x_in;
            y_q <= y_in;
        end else if (busy && stage != STAGE_W'(CORDIC_STAGES)) begin
            if (!y_q[CORDIC_WIDTH-1]) begin
                x_q <= x_q + (y_q >>> stage);
                y_q <= y_q - (x_q >>> stage);
            end else begin
                x_q <= x_q - (y_q >>> stage);
                y_q <= y_q + (x_q >>> stage);
            end
        end
    end

    // Gain left in, the client compensates
    assign srv.mag = x_q;
    assign srv.ack = ack_q;

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!nreset)
        $rose(srv.ack) |-> srv.req
    );

endmodule

`default_nettype wire

//--- cordic_if.sv
`timescale 1ns/1ps
`default_nettype none

// One magnitude request, four-phase req/ack
interface cordic_if import cordic_pkg::*; ();

    cordic_t x;
    cordic_t y;
    logic    req;
    logic    ack;

    // Scaled by K and by 2**GUARD_BITS
    cordic_t mag;

    modport client (
        output x,
        output y,
        output req,
        input  ack,
        input  mag
    );

    modport server (
        input  x,
        input  y,
        input  req,
        output ack,
        output mag
    );

endinterface

`default_nettype wire

//--- cordic_pkg.sv
`default_nettype none

package cordic_pkg;

    // Internal datapath
    localparam int CORDIC_WIDTH  = 22;
    localparam int CORDIC_STAGES = 16;

    // Extra fraction bits applied to the inputs inside the CORDIC
    localparam int GUARD_BITS    = 2;

    typedef logic signed [CORDIC_WIDTH-1:0] cordic_t;

    // 1/K in Q0.16, K being the gain of 16 micro-rotations
    localparam int GAIN_WIDTH = 16;
    localparam logic [GAIN_WIDTH-1:0] GAIN_INV = 16'd39797;

endpackage

`default_nettype wire

//--- ica_pkg.sv
`default_nettype none

package ica_pkg;

    // Vector shape
    localparam int DIM          = 4;
    localparam int SAMPLE_WIDTH = 16;

    // Wide enough for the norm of a full-scale difference vector
    localparam int NORM_WIDTH   = 18;

    // Serial input sample
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // One extra bit so new minus old never wraps
    typedef logic signed [SAMPLE_WIDTH:0]   diff_t;

    typedef logic [NORM_WIDTH-1:0]          norm_t;

    // Whole vectors
    typedef sample_t vec_t [DIM];
    typedef diff_t   diff_vec_t [DIM];

    // Converged when the difference norm is at most this
    localparam norm_t THRESHOLD = norm_t'(32);

    // Run controller
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        DIFF,
        NORM,
        REPORT
    } conv_state_t;

endpackage

`default_nettype wire
